// File: cmdProc.sv
`timescale 1ns/1ns

module cmdProc import knightPkg::*; (
  input  logic        clk,
  input  logic        reset,
  input  logic        cmdRdy,
  input  logic [15:0] cmd,
  output logic        sendResp,
  output logic [7:0]  resp,
  output logic        calDone,
  output logic        moving,
  output logic [7:0]  heading,
  output logic [2:0]  xx,
  output logic [2:0]  yy
);

  procState_t         state;
  opcode_t            op;
  logic [7:0]         cmdHead;
  logic [3:0]         cmdCount;
  logic               headOk;
  logic               onBoard;
  logic               moveOk;
  logic [TIMER_W-1:0] timer;
  logic [3:0]         remaining;

  // Split the command into its three fields
  assign op       = opcode_t'(cmd[15:12]);
  assign cmdHead  = cmd[11:4];
  assign cmdCount = cmd[3:0];

  ////////////////////////////////////////////////////////////////////////////
  // Move validation
  ////////////////////////////////////////////////////////////////////////////

  // Sums are taken at five bits so a long count cannot wrap back onto the board
  always_comb begin
    headOk  = 1'b1;
    onBoard = 1'b0;
    case (cmdHead)
      HEAD_NORTH: onBoard = (5'(yy) + 5'(cmdCount)) <= 5'(BOARD_MAX);
      HEAD_SOUTH: onBoard = cmdCount <= 4'(yy);
      HEAD_EAST:  onBoard = (5'(xx) + 5'(cmdCount)) <= 5'(BOARD_MAX);
      HEAD_WEST:  onBoard = cmdCount <= 4'(xx);
      default:    headOk = 1'b0;
    endcase
  end

  // Moves are only legal once the gyro has been calibrated
  assign moveOk = (op == MOVE) && calDone && headOk && onBoard && (cmdCount != 4'd0);

  ////////////////////////////////////////////////////////////////////////////
  // Command FSM
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (reset) begin
      state     <= ST_IDLE;
      sendResp  <= 1'b0;
      calDone   <= 1'b0;
      moving    <= 1'b0;
      heading   <= HEAD_NORTH;
      xx        <= START_XX;
      yy        <= START_YY;
      timer     <= '0;
      remaining <= '0;
    end else begin
      sendResp <= 1'b0;
      case (state)
        ST_IDLE: begin
          if (cmdRdy) begin
            timer <= '0;
            if (op == CAL_GYRO) begin
              state <= ST_CAL;
            end else if (moveOk) begin
              heading   <= cmdHead;
              moving    <= 1'b1;
              remaining <= cmdCount;
              state     <= ST_MOVE;
            end else begin
              // Rejected commands are answered at once and change nothing
              resp     <= ACK_NEG;
              sendResp <= 1'b1;
            end
          end
        end
        ST_CAL: begin
          if (timer == CAL_LAST) begin
            calDone <= 1'b1;
            state   <= ST_RESP;
          end else begin
            timer <= timer + 1'b1;
          end
        end
        ST_MOVE: begin
          // One square per STEP_CYCLES along the latched heading
          if (timer == STEP_LAST) begin
            timer     <= '0;
            remaining <= remaining - 1'b1;
            case (heading)
              HEAD_NORTH: yy <= yy + 1'b1;
              HEAD_SOUTH: yy <= yy - 1'b1;
              HEAD_EAST:  xx <= xx + 1'b1;
              default:    xx <= xx - 1'b1;
            endcase
            if (remaining == 4'd1) begin
              moving <= 1'b0;
              state  <= ST_RESP;
            end
          end else begin
            timer <= timer + 1'b1;
          end
        end
        default: begin
          resp     <= ACK_POS;
          sendResp <= 1'b1;
          state    <= ST_IDLE;
        end
      endcase
    end
  end

endmodule

// File: knightPkg.sv
package knightPkg;

  ////////////////////////////////////////////////////////////////////////////
  // Command encoding
  ////////////////////////////////////////////////////////////////////////////

  // Opcode sits in bits 15 to 12 of a command, other values are unknown
  typedef enum logic [3:0] {
    CAL_GYRO = 4'd2,
    MOVE     = 4'd4
  } opcode_t;

  // Heading codes carried in bits 11 to 4
  localparam logic [7:0] HEAD_NORTH = 8'h00;
  localparam logic [7:0] HEAD_WEST  = 8'h3F;
  localparam logic [7:0] HEAD_SOUTH = 8'h7F;
  localparam logic [7:0] HEAD_EAST  = 8'hBF;

  // Acknowledge bytes returned for each command
  localparam logic [7:0] ACK_POS = 8'hA5;
  localparam logic [7:0] ACK_NEG = 8'h5A;

  ////////////////////////////////////////////////////////////////////////////
  // Board and timing
  ////////////////////////////////////////////////////////////////////////////

  // The board spans coordinates 0 to BOARD_MAX on each axis
  localparam logic [2:0] BOARD_MAX = 3'd4;
  localparam logic [2:0] START_XX  = 3'd2;
  localparam logic [2:0] START_YY  = 3'd2;

  localparam int CAL_CYCLES  = 64;
  localparam int STEP_CYCLES = 16;

  // One timer serves both calibration and stepping, so it is sized for the longer
  localparam int TIMER_W = $clog2(CAL_CYCLES);
  localparam logic [TIMER_W-1:0] CAL_LAST  = TIMER_W'(CAL_CYCLES - 1);
  localparam logic [TIMER_W-1:0] STEP_LAST = TIMER_W'(STEP_CYCLES - 1);

  typedef enum logic [1:0] {ST_IDLE, ST_CAL, ST_MOVE, ST_RESP} procState_t;

endpackage

// File: knightTour.f
uartPkg.sv
knightPkg.sv
uartRx.sv
uartTx.sv
remoteLink.sv
cmdProc.sv
knightTour.sv
knightTour_sva.sv
knightTour_tb.sv

// File: knightTour.sv
`timescale 1ns/1ns

module knightTour (
  input  logic       clk,
  input  logic       reset,
  input  logic       rx,
  output logic       tx,
  output logic       calDone,
  output logic       moving,
  output logic [7:0] heading,
  output logic [2:0] xx,
  output logic [2:0] yy
);

  // Command and response strobes between the link and the processor
  logic        cmdRdy;
  logic [15:0] cmd;
  logic        sendResp;
  logic [7:0]  resp;

  ////////////////////////////////////////////////////////////////////////////
  // Serial link to the host
  ////////////////////////////////////////////////////////////////////////////

  remoteLink u_link (
    .clk(clk), .reset(reset), .rx(rx), .sendResp(sendResp), .resp(resp),
    .tx(tx), .cmdRdy(cmdRdy), .cmd(cmd)
  );

  // Position and heading stand in for what the physics model would report
  cmdProc u_proc (
    .clk(clk), .reset(reset), .cmdRdy(cmdRdy), .cmd(cmd),
    .sendResp(sendResp), .resp(resp), .calDone(calDone), .moving(moving),
    .heading(heading), .xx(xx), .yy(yy)
  );

endmodule

// File: knightTour_sva.sv
`timescale 1ns/1ns

module cmdProcSva import knightPkg::*; (
  input logic       clk,
  input logic       reset,
  input logic       sendResp,
  input logic       calDone,
  input logic       moving,
  input logic [2:0] xx,
  input logic [2:0] yy
);

  // The knight never leaves the 5x5 board
  assert property (@(posedge clk) disable iff (reset) xx <= BOARD_MAX && yy <= BOARD_MAX)
    else $error("knight position left the board");

  // Calibration is sticky until the next reset
  assert property (@(posedge clk) disable iff (reset) calDone |=> calDone)
    else $error("calDone fell outside reset");

  // One acknowledge per command, so the strobe lasts a single cycle
  assert property (@(posedge clk) disable iff (reset) sendResp |=> !sendResp)
    else $error("sendResp held for more than one cycle");

  // No motion before calibration
  assert property (@(posedge clk) disable iff (reset) !calDone |-> !moving)
    else $error("moving high while calDone is low");

endmodule

bind cmdProc cmdProcSva u_sva (.*);

// File: knightTour_tb.sv
`timescale 1ns/1ns

module knightTour_tb import knightPkg::*; ();

  // About 45 commands at up to roughly 1000 cycles each, with margin
  localparam int TIMEOUT_CYCLES = 60000;

  logic        clk;
  logic        reset;
  logic        hostStart;
  logic [7:0]  hostData;
  logic        hostBusy;
  logic        hostLine;
  logic        dutLine;
  logic [7:0]  ackByte;
  logic        ackRdy;
  logic        calDone;
  logic        moving;
  logic [7:0]  heading;
  logic [2:0]  xx;
  logic [2:0]  yy;
  integer      seed;
  int          cycles;
  int          ackCount;
  string       curName;
  logic [15:0] curCmd;
  logic [22:0] expected;
  logic        sawMoving;
  // Model state, updated after every acknowledge
  logic [2:0]  mX;
  logic [2:0]  mY;
  logic [7:0]  mHead;
  logic        mCal;

  ////////////////////////////////////////////////////////////////////////////
  // DUT and host-side remote
  ////////////////////////////////////////////////////////////////////////////

  uartTx u_hostTx (
    .clk(clk), .reset(reset), .start(hostStart), .data(hostData),
    .tx(hostLine), .busy(hostBusy)
  );

  knightTour u_dut (
    .clk(clk), .reset(reset), .rx(hostLine), .tx(dutLine), .calDone(calDone),
    .moving(moving), .heading(heading), .xx(xx), .yy(yy)
  );

  // The host listens on the DUT's transmit line for the acknowledge
  uartRx u_hostRx (.clk(clk), .reset(reset), .rx(dutLine), .data(ackByte), .rdy(ackRdy));

  always #2 clk = ~clk;

  // Free-running cycle count guards against a command that never answers
  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= TIMEOUT_CYCLES) begin
      $display("ERROR: run exceeded %0d cycles, still waiting during %s",
               TIMEOUT_CYCLES, curName);
      abortRun();
    end
  end

  task automatic abortRun();
    $display("TEST RESULT: FAIL");
    $fatal(1);
  endtask

  task automatic checkValue(input string name, input logic [7:0] exp, input logic [7:0] act);
    if (act !== exp) begin
      $display("MISMATCH %s expected %h actual %h", name, exp, act);
      abortRun();
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Reference model of the command rules
  ////////////////////////////////////////////////////////////////////////////

  // Returns {ack, calibrated, heading, xx, yy} after one command
  function automatic logic [22:0] refModel(input logic [2:0] x, input logic [2:0] y,
                                           input logic [7:0] head, input logic cal,
                                           input logic [15:0] c);
    logic [7:0] ack;
    logic [7:0] newHead;
    logic       newCal;
    logic       headKnown;
    int         nx;
    int         ny;
    int         n;
    ack       = ACK_NEG;
    newHead   = head;
    newCal    = cal;
    headKnown = 1'b1;
    nx        = int'(x);
    ny        = int'(y);
    n         = int'(c[3:0]);
    if (c[15:12] == CAL_GYRO) begin
      ack    = ACK_POS;
      newCal = 1'b1;
    end else if (c[15:12] == MOVE && cal && n != 0) begin
      case (c[11:4])
        HEAD_NORTH: ny = ny + n;
        HEAD_SOUTH: ny = ny - n;
        HEAD_EAST:  nx = nx + n;
        HEAD_WEST:  nx = nx - n;
        default:    headKnown = 1'b0;
      endcase
      // The whole move must end on the board or nothing happens
      if (headKnown && nx >= 0 && ny >= 0 && nx <= int'(BOARD_MAX) && ny <= int'(BOARD_MAX)) begin
        ack     = ACK_POS;
        newHead = c[11:4];
      end
    end
    if (ack == ACK_NEG || c[15:12] == CAL_GYRO) begin
      nx = int'(x);
      ny = int'(y);
    end
    return {ack, newCal, newHead, 3'(nx), 3'(ny)};
  endfunction

  // Each acknowledge is checked against the model, then the model steps on
  always @(negedge clk) begin
    if (moving) sawMoving = 1'b1;
    if (ackRdy) begin
      expected = refModel(mX, mY, mHead, mCal, curCmd);
      checkValue({curName, " ack"}, expected[22:15], ackByte);
      checkValue({curName, " calDone"}, 8'(expected[14]), 8'(calDone));
      checkValue({curName, " heading"}, expected[13:6], heading);
      checkValue({curName, " xx"}, 8'(expected[5:3]), 8'(xx));
      checkValue({curName, " yy"}, 8'(expected[2:0]), 8'(yy));
      checkValue({curName, " moving"}, 8'h00, 8'(moving));
      // Only an accepted move raises moving while the command runs
      checkValue({curName, " moved"},
                 8'(expected[22:15] == ACK_POS && curCmd[15:12] == MOVE), 8'(sawMoving));
      {mCal, mHead, mX, mY} = expected[14:0];
      ackCount = ackCount + 1;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Host stimulus
  ////////////////////////////////////////////////////////////////////////////

  task automatic sendByte(input logic [7:0] b);
    @(posedge clk);
    hostStart <= 1'b1;
    hostData  <= b;
    @(posedge clk);
    hostStart <= 1'b0;
    // busy is up by the next falling edge and drops after the stop bit
    @(negedge clk);
    while (hostBusy) @(negedge clk);
  endtask

  // High byte first, then wait for the compare process to see the acknowledge
  task automatic sendCommand(input string name, input logic [15:0] c);
    int startCount;
    curName    = name;
    curCmd     = c;
    startCount = ackCount;
    sawMoving  = 1'b0;
    sendByte(c[15:8]);
    sendByte(c[7:0]);
    while (ackCount == startCount) @(posedge clk);
  endtask

  task automatic expectPos(input string name, input logic [2:0] x, input logic [2:0] y);
    checkValue({name, " xx"}, 8'(x), 8'(xx));
    checkValue({name, " yy"}, 8'(y), 8'(yy));
  endtask

  initial begin
    logic [31:0] r;
    logic [3:0]  op;
    logic [7:0]  head;
    clk       = 1'b0;
    reset     = 1'b1;
    hostStart = 1'b0;
    hostData  = 8'h00;
    seed      = 32'h37094c2a;
    cycles    = 0;
    ackCount  = 0;
    sawMoving = 1'b0;
    curName   = "reset";
    curCmd    = 16'h0000;
    mX        = START_XX;
    mY        = START_YY;
    mHead     = HEAD_NORTH;
    mCal      = 1'b0;
    repeat (10) @(posedge clk);
    reset <= 1'b0;
    repeat (2) @(negedge clk);

    // Reset state
    expectPos("reset", START_XX, START_YY);
    checkValue("reset heading", HEAD_NORTH, heading);
    checkValue("reset moving", 8'h00, 8'(moving));
    checkValue("reset calDone", 8'h00, 8'(calDone));
    sendCommand("move before calibration", 16'h4001);

    sendCommand("calibrate", 16'h2000);
    sendCommand("west one", 16'h43F1);
    expectPos("west one", 3'd1, 3'd2);
    sendCommand("north one", 16'h4001);
    sendCommand("south one", 16'h47F1);
    sendCommand("east one", 16'h4BF1);

    // Multi-square moves to the board edges
    sendCommand("west again", 16'h43F1);
    sendCommand("east three", 16'h4BF3);
    expectPos("east three", 3'd4, 3'd2);
    sendCommand("north two", 16'h4002);
    sendCommand("south four", 16'h47F4);
    expectPos("south four", 3'd4, 3'd0);

    // Rejected commands leave the knight where it is
    sendCommand("off board", 16'h4BF1);
    sendCommand("unknown heading", 16'h4121);
    sendCommand("zero count", 16'h47F0);
    sendCommand("unknown opcode", 16'h7001);
    expectPos("after rejects", 3'd4, 3'd0);

    for (int i = 0; i < 30; i++) begin
      r = $random(seed);
      case (r[1:0])
        2'd0:    op = CAL_GYRO;
        2'd3:    op = r[7:4];
        default: op = MOVE;
      endcase
      case (r[10:8])
        3'd0:    head = HEAD_NORTH;
        3'd1:    head = HEAD_WEST;
        3'd2:    head = HEAD_SOUTH;
        3'd3:    head = HEAD_EAST;
        default: head = r[23:16];
      endcase
      sendCommand($sformatf("random %0d", i), {op, head, r[15:12]});
    end

    $display("TEST RESULT: PASS");
    $finish;
  end

endmodule

// File: remoteLink.sv
`timescale 1ns/1ns

module remoteLink (
  input  logic        clk,
  input  logic        reset,
  input  logic        rx,
  input  logic        sendResp,
  input  logic [7:0]  resp,
  output logic        tx,
  output logic        cmdRdy,
  output logic [15:0] cmd
);

  logic [7:0] rxData;
  logic       rxRdy;
  logic [7:0] highByte;
  logic       lowNext;
  logic [7:0] respReg;
  logic       respPending;
  logic       txStart;
  logic       txBusy;

  uartRx u_rx (.clk(clk), .reset(reset), .rx(rx), .data(rxData), .rdy(rxRdy));

  ////////////////////////////////////////////////////////////////////////////
  // Command assembly
  ////////////////////////////////////////////////////////////////////////////

  // The toggle says whether the next byte is the low half of a command
  always_ff @(posedge clk) begin
    if (reset) begin
      lowNext <= 1'b0;
      cmdRdy  <= 1'b0;
    end else begin
      cmdRdy <= rxRdy && lowNext;
      if (rxRdy) lowNext <= !lowNext;
    end
  end

  // High byte arrives first and waits here for its partner
  always_ff @(posedge clk) begin
    if (rxRdy && !lowNext) highByte <= rxData;
    if (rxRdy && lowNext) cmd <= {highByte, rxData};
  end

  ////////////////////////////////////////////////////////////////////////////
  // Response path
  ////////////////////////////////////////////////////////////////////////////

  // Hold one response until the transmitter is free
  always_ff @(posedge clk) begin
    if (reset) respPending <= 1'b0;
    else if (sendResp) respPending <= 1'b1;
    else if (txStart) respPending <= 1'b0;
  end

  always_ff @(posedge clk) begin
    if (sendResp) respReg <= resp;
  end

  assign txStart = respPending && !txBusy;

  uartTx u_tx (
    .clk(clk), .reset(reset), .start(txStart), .data(respReg), .tx(tx), .busy(txBusy)
  );

endmodule

// File: run.sh
#!/bin/sh
# Compile the knightTour testbench with Verilator and run it from the project root
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module knightTour_tb -Mdir obj_dir -f knightTour.f
if [ $? -ne 0 ]; then
  echo "Verilator compile failed"
  exit 1
fi

./obj_dir/VknightTour_tb
status=$?
if [ $status -ne 0 ]; then
  echo "Simulation failed with status $status"
  exit $status
fi
exit 0

// File: uartPkg.sv
package uartPkg;

  ////////////////////////////////////////////////////////////////////////////
  // Serial link timing for 8N1 frames
  ////////////////////////////////////////////////////////////////////////////

  // Clock cycles spent on each serial bit
  localparam int BAUD_DIV = 16;

  // Width of the bit-period counters in both directions
  localparam int BAUD_W = $clog2(BAUD_DIV);

  // Last count of a full bit period
  localparam logic [BAUD_W-1:0] BAUD_LAST = BAUD_W'(BAUD_DIV - 1);

  // Count at which the receiver sits in the middle of the start bit
  localparam logic [BAUD_W-1:0] BAUD_MID = BAUD_W'(BAUD_DIV / 2 - 1);

  // Receiver FSM states
  typedef enum logic [1:0] {RX_IDLE, RX_START, RX_DATA, RX_STOP} rxState_t;

  // Transmitter FSM
  typedef enum logic [1:0] {TX_IDLE, TX_START, TX_DATA, TX_STOP} txState_t;

endpackage

// File: uartRx.sv
`timescale 1ns/1ns

module uartRx import uartPkg::*; (
  input  logic       clk,
  input  logic       reset,
  input  logic       rx,
  output logic [7:0] data,
  output logic       rdy
);

  logic              rxMeta;
  logic              rxSync;
  logic              rxPrev;
  rxState_t          state;
  logic [BAUD_W-1:0] baudCnt;
  logic [2:0]        bitCnt;
  logic [7:0]        shiftReg;

  ////////////////////////////////////////////////////////////////////////////
  // Input synchronizer and start edge
  ////////////////////////////////////////////////////////////////////////////

  // The line idles high, so the flops come out of reset at one
  always_ff @(posedge clk) begin
    if (reset) begin
      rxMeta <= 1'b1;
      rxSync <= 1'b1;
      rxPrev <= 1'b1;
    end else begin
      rxMeta <= rx;
      rxSync <= rxMeta;
      rxPrev <= rxSync;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Bit sampling FSM
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (reset) begin
      state   <= RX_IDLE;
      baudCnt <= '0;
      bitCnt  <= '0;
      rdy     <= 1'b0;
    end else begin
      rdy <= 1'b0;
      case (state)
        RX_IDLE: begin
          // A falling edge on the synchronized line marks a start bit
          if (rxPrev && !rxSync) begin
            baudCnt <= '0;
            state   <= RX_START;
          end
        end
        RX_START: begin
          // Recheck the line at mid start bit so a glitch is dropped
          if (baudCnt == BAUD_MID) begin
            baudCnt <= '0;
            bitCnt  <= '0;
            state   <= rxSync ? RX_IDLE : RX_DATA;
          end else begin
            baudCnt <= baudCnt + 1'b1;
          end
        end
        RX_DATA: begin
          // A full period after a mid-bit point lands on the next mid-bit point
          if (baudCnt == BAUD_LAST) begin
            baudCnt <= '0;
            bitCnt  <= bitCnt + 1'b1;
            if (bitCnt == 3'd7) state <= RX_STOP;
          end else begin
            baudCnt <= baudCnt + 1'b1;
          end
        end
        default: begin
          // Middle of the stop bit ends the frame
          if (baudCnt == BAUD_LAST) begin
            rdy   <= 1'b1;
            state <= RX_IDLE;
          end else begin
            baudCnt <= baudCnt + 1'b1;
          end
        end
      endcase
    end
  end

  // Bits arrive LSB first and enter at the top of the shift register
  always_ff @(posedge clk) begin
    if (state == RX_DATA && baudCnt == BAUD_LAST) shiftReg <= {rxSync, shiftReg[7:1]};
  end

  // The byte holds still from the last data bit until the next frame starts
  assign data = shiftReg;

endmodule

// File: uartTx.sv
`timescale 1ns/1ns

module uartTx import uartPkg::*; (
  input  logic       clk,
  input  logic       reset,
  input  logic       start,
  input  logic [7:0] data,
  output logic       tx,
  output logic       busy
);

  txState_t          state;
  logic [BAUD_W-1:0] baudCnt;
  logic [2:0]        bitCnt;
  logic [9:0]        frame;
  logic              bitEnd;

  // Each bit is held for one full baud period
  assign bitEnd = (baudCnt == BAUD_LAST);

  ////////////////////////////////////////////////////////////////////////////
  // Frame timing FSM
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (reset) begin
      state   <= TX_IDLE;
      baudCnt <= '0;
      bitCnt  <= '0;
      frame   <= '1;
    end else begin
      case (state)
        TX_IDLE: begin
          // Frame is stop bit, data LSB first, then start bit at the bottom
          if (start) begin
            frame   <= {1'b1, data, 1'b0};
            baudCnt <= '0;
            state   <= TX_START;
          end
        end
        TX_START, TX_DATA: begin
          if (bitEnd) begin
            baudCnt <= '0;
            frame   <= {1'b1, frame[9:1]};
            if (state == TX_START) begin
              bitCnt <= '0;
              state  <= TX_DATA;
            end else begin
              bitCnt <= bitCnt + 1'b1;
              if (bitCnt == 3'd7) state <= TX_STOP;
            end
          end else begin
            baudCnt <= baudCnt + 1'b1;
          end
        end
        default: begin
          // The stop bit is the last one on the line, and the shift has filled with ones
          if (bitEnd) state <= TX_IDLE;
          else baudCnt <= baudCnt + 1'b1;
        end
      endcase
    end
  end

  // The low bit of the frame is always the bit on the line
  assign tx   = frame[0];
  assign busy = (state != TX_IDLE);

endmodule
